/* Makefile */
VERILATOR ?= verilator
TOP       ?= commit_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS RUN_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/commit_checker.sv */
`timescale 1ns/100ps

module commit_checker (
    input logic                                                clk,
    input logic                                                rst,
    input commit_pkg::wb_slot_t  [commit_pkg::COMMIT_WIDTH-1:0] wb_i,
    input commit_pkg::rf_write_t [commit_pkg::COMMIT_WIDTH-1:0] rf_write_i,
    input commit_pkg::stage_vec_t                               advance_i,
    input commit_pkg::stage_vec_t                               clear_i,
    input logic                                                 redirect_valid_i,
    input logic                                                 flush_all_i
);

    int fail_count = 0;

    // A bubble only goes into a stage that holds still
    a_clear_stalled: assert property (@(posedge clk) disable iff (rst)
        (clear_i & advance_i) == '0)
        else begin
            fail_count++;
            $error("clear bit set on an advancing stage");
        end

    a_redirect_flush: assert property (@(posedge clk) disable iff (rst)
        redirect_valid_i == flush_all_i)
        else begin
            fail_count++;
            $error("redirect valid differs from the flush request");
        end

    a_no_excp_write: assert property (@(posedge clk) disable iff (rst)
        !((wb_i[0].excp && rf_write_i[0].we) || (wb_i[1].excp && rf_write_i[1].we)))
        else begin
            fail_count++;
            $error("register write enabled on an excepting slot");
        end

endmodule

bind commit_ctrl_top commit_checker u_checker (
    .clk              (clk),
    .rst              (rst),
    .wb_i             (wb_i),
    .rf_write_i       (rf_write_o),
    .advance_i        (advance_o),
    .clear_i          (clear_o),
    .redirect_valid_i (redirect_valid_o),
    .flush_all_i      (flush_all)
);

/* bench/commit_tb.sv */
`timescale 1ns/100ps

module commit_tb;

    localparam int NUM_ROWS       = 18;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 4 + 40;

    // Where the redirect should land and where BADV comes from
    typedef enum logic [2:0] {R_NONE, R_EENTRY, R_TLBR, R_ERA, R_PC0, R_PC4} redir_e;
    typedef enum logic [1:0] {VA_NONE, VA_PC, VA_MEM} va_e;

    typedef struct packed {
        commit_pkg::op_kind_e   op0;
        commit_pkg::op_kind_e   op1;
        commit_pkg::excp_vec_t  vec0;
        commit_pkg::excp_vec_t  vec1;
        logic                   refetch0;
        logic [1:0]             br0;
        logic [5:0]             ready;
        logic [1:0]             mask;
        redir_e                 redir;
        commit_pkg::ecode_t     ecode;
        commit_pkg::esubcode_t  esub;
        va_e                    va;
        commit_pkg::stage_vec_t adv;
        commit_pkg::stage_vec_t clr;
    } row_t;

    localparam commit_pkg::op_kind_e NRM = commit_pkg::OP_NORMAL;
    localparam commit_pkg::op_kind_e BRN = commit_pkg::OP_BRANCH;
    localparam commit_pkg::op_kind_e SYC = commit_pkg::OP_SYSCALL;
    localparam commit_pkg::op_kind_e ERT = commit_pkg::OP_ERTN;
    localparam commit_pkg::op_kind_e IDL = commit_pkg::OP_IDLE;

    logic clk;
    logic rst;

    commit_pkg::wb_slot_t  [commit_pkg::COMMIT_WIDTH-1:0] wb;
    logic [1:0]                                           ex_ready;
    logic [1:0]                                           mem1_ready;
    logic [1:0]                                           mem2_ready;
    commit_pkg::csr_wr_t                                  csr_wr;
    commit_pkg::rf_write_t [commit_pkg::COMMIT_WIDTH-1:0] rf_write_o;
    logic                  [commit_pkg::COMMIT_WIDTH-1:0] commit_mask_o;
    logic                                                 redirect_valid_o;
    commit_pkg::addr_t                                    redirect_pc_o;
    logic                                                 in_idle_o;
    commit_pkg::stage_vec_t                               advance_o;
    commit_pkg::stage_vec_t                               flush_o;
    commit_pkg::stage_vec_t                               clear_o;
    commit_pkg::addr_t                                    era_o;
    commit_pkg::addr_t                                    badv_o;
    commit_pkg::ecode_t                                   estat_ecode_o;
    commit_pkg::esubcode_t                                estat_esubcode_o;

    row_t rows [NUM_ROWS];
    logic [31:0] lcg_state = 32'ha6dea79c;
    int checks = 0;
    int errors = 0;
    int cycles = 0;
    commit_pkg::addr_t eentry_val;
    commit_pkg::addr_t tlbr_val;

    // Expected trap CSR state, starts at the reset values
    commit_pkg::addr_t     exp_era = '0;
    commit_pkg::addr_t     exp_badv = '0;
    commit_pkg::ecode_t    exp_ecode = '0;
    commit_pkg::esubcode_t exp_esub = '0;
    logic                  exp_idle = 1'b0;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    commit_ctrl_top dut_i (
        .clk              (clk),
        .rst              (rst),
        .wb_i             (wb),
        .ex_ready_i       (ex_ready),
        .mem1_ready_i     (mem1_ready),
        .mem2_ready_i     (mem2_ready),
        .csr_wr_i         (csr_wr),
        .rf_write_o       (rf_write_o),
        .commit_mask_o    (commit_mask_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o),
        .in_idle_o        (in_idle_o),
        .advance_o        (advance_o),
        .flush_o          (flush_o),
        .clear_o          (clear_o),
        .era_o            (era_o),
        .badv_o           (badv_o),
        .estat_ecode_o    (estat_ecode_o),
        .estat_esubcode_o (estat_esubcode_o)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Ready bits are {ex, mem1, mem2}; vec bit 9 ALE, 11 TLBR_M, 7 INE, 1 ADEF
    task automatic fill_table();
        rows[0]  = '{NRM, NRM, 16'h0000, 16'h0000, 1'b0, 2'b00, 6'h3f, 2'b11,
                     R_NONE, 6'h00, 9'h000, VA_NONE, 7'h7f, 7'h00};
        rows[1]  = '{NRM, NRM, 16'h0200, 16'h0000, 1'b0, 2'b00, 6'h3f, 2'b00,
                     R_EENTRY, commit_pkg::ECODE_ALE, 9'h000, VA_MEM, 7'h7f, 7'h00};
        rows[2]  = '{NRM, NRM, 16'h0800, 16'h0000, 1'b0, 2'b00, 6'h3f, 2'b00,
                     R_TLBR, commit_pkg::ECODE_TLBR, 9'h000, VA_MEM, 7'h7f, 7'h00};
        rows[3]  = '{NRM, NRM, 16'h0000, 16'h0080, 1'b0, 2'b00, 6'h3f, 2'b01,
                     R_EENTRY, commit_pkg::ECODE_INE, 9'h000, VA_NONE, 7'h7f, 7'h00};
        rows[4]  = '{NRM, NRM, 16'h0202, 16'h0000, 1'b0, 2'b00, 6'h3f, 2'b00,
                     R_EENTRY, commit_pkg::ECODE_ADE, commit_pkg::ESUBCODE_ADEF, VA_PC,
                     7'h7f, 7'h00};
        // ADEM together with PIL in the younger slot
        rows[5]  = '{NRM, NRM, 16'h0000, 16'h8400, 1'b0, 2'b00, 6'h3f, 2'b01,
                     R_EENTRY, commit_pkg::ECODE_ADE, commit_pkg::ESUBCODE_ADEM, VA_MEM,
                     7'h7f, 7'h00};
        rows[6]  = '{NRM, NRM, 16'h0004, 16'h0000, 1'b0, 2'b00, 6'h3f, 2'b00,
                     R_TLBR, commit_pkg::ECODE_TLBR, 9'h000, VA_PC, 7'h7f, 7'h00};
        rows[7]  = '{SYC, NRM, 16'h0020, 16'h0000, 1'b0, 2'b00, 6'h3f, 2'b00,
                     R_EENTRY, commit_pkg::ECODE_SYS, 9'h000, VA_NONE, 7'h7f, 7'h00};
        rows[8]  = '{ERT, NRM, 16'h0000, 16'h0000, 1'b0, 2'b00, 6'h3f, 2'b01,
                     R_ERA, 6'h00, 9'h000, VA_NONE, 7'h7f, 7'h00};
        rows[9]  = '{IDL, NRM, 16'h0000, 16'h0000, 1'b0, 2'b00, 6'h3f, 2'b01,
                     R_PC0, 6'h00, 9'h000, VA_NONE, 7'h7f, 7'h00};
        // Interrupt wakes the core from idle
        rows[10] = '{NRM, NRM, 16'h0001, 16'h0000, 1'b0, 2'b00, 6'h3f, 2'b00,
                     R_EENTRY, commit_pkg::ECODE_INT, 9'h000, VA_NONE, 7'h7f, 7'h00};
        rows[11] = '{NRM, NRM, 16'h0000, 16'h0000, 1'b1, 2'b00, 6'h3f, 2'b11,
                     R_PC4, 6'h00, 9'h000, VA_NONE, 7'h7f, 7'h00};
        rows[12] = '{BRN, NRM, 16'h0000, 16'h0000, 1'b0, 2'b10, 6'h3f, 2'b01,
                     R_NONE, 6'h00, 9'h000, VA_NONE, 7'h7f, 7'h00};
        rows[13] = '{BRN, NRM, 16'h0000, 16'h0000, 1'b0, 2'b11, 6'h3f, 2'b11,
                     R_NONE, 6'h00, 9'h000, VA_NONE, 7'h7f, 7'h00};
        // Back-pressure from mem1, then ex, then mem2
        rows[14] = '{NRM, NRM, 16'h0000, 16'h0000, 1'b0, 2'b00, 6'h3b, 2'b11,
                     R_NONE, 6'h00, 9'h000, VA_NONE, 7'h03, 7'h04};
        rows[15] = '{NRM, NRM, 16'h0000, 16'h0000, 1'b0, 2'b00, 6'h1f, 2'b11,
                     R_NONE, 6'h00, 9'h000, VA_NONE, 7'h07, 7'h08};
        rows[16] = '{NRM, NRM, 16'h0000, 16'h0000, 1'b0, 2'b00, 6'h3e, 2'b11,
                     R_NONE, 6'h00, 9'h000, VA_NONE, 7'h01, 7'h02};
        rows[17] = '{NRM, ERT, 16'h0000, 16'h0000, 1'b0, 2'b00, 6'h3f, 2'b11,
                     R_ERA, 6'h00, 9'h000, VA_NONE, 7'h7f, 7'h00};
    endtask

    task automatic run_row(input row_t rw, input int idx);
        commit_pkg::addr_t      pc0;
        commit_pkg::addr_t      tpc;
        commit_pkg::addr_t      tmem;
        commit_pkg::addr_t      exp_pc;
        commit_pkg::stage_vec_t exp_flush;
        int                     errs_before;
        errs_before = errors;
        @(negedge clk);
        pc0 = lcg_next() & 32'hffff_fffc;
        for (int i = 0; i < commit_pkg::COMMIT_WIDTH; i++) begin
            wb[i]          = '0;
            wb[i].valid    = 1'b1;
            wb[i].pc       = pc0 + 32'(4 * i);
            wb[i].mem_addr = lcg_next();
            wb[i].rf.we    = 1'b1;
            wb[i].rf.idx   = 5'(lcg_next());
            wb[i].rf.data  = lcg_next();
        end
        wb[0].op              = rw.op0;
        wb[1].op              = rw.op1;
        wb[0].excp_vec        = rw.vec0;
        wb[1].excp_vec        = rw.vec1;
        wb[0].excp            = |rw.vec0;
        wb[1].excp            = |rw.vec1;
        wb[0].need_refetch    = rw.refetch0;
        wb[0].is_taken        = rw.br0[1];
        wb[0].predicted_taken = rw.br0[0];
        {ex_ready, mem1_ready, mem2_ready} = rw.ready;
        #1;
        case (rw.redir)
            R_EENTRY: exp_pc = eentry_val;
            R_TLBR:   exp_pc = tlbr_val;
            R_ERA:    exp_pc = exp_era;
            R_PC0:    exp_pc = pc0;
            R_PC4:    exp_pc = pc0 + 32'd4;
            default:  exp_pc = '0;
        endcase
        exp_flush = (rw.redir != R_NONE) ? '1 : '0;
        check("commit_mask_o", 32'(commit_mask_o), 32'(rw.mask));
        check("redirect_valid_o", 32'(redirect_valid_o), 32'(rw.redir != R_NONE));
        if (rw.redir != R_NONE) begin
            check("redirect_pc_o", redirect_pc_o, exp_pc);
        end
        check("flush_o", 32'(flush_o), 32'(exp_flush));
        check("advance_o", 32'(advance_o), 32'(rw.adv));
        check("clear_o", 32'(clear_o), 32'(rw.clr));
        for (int i = 0; i < commit_pkg::COMMIT_WIDTH; i++) begin
            check($sformatf("rf_write_o[%0d].we", i), 32'(rf_write_o[i].we), 32'(rw.mask[i]));
            check($sformatf("rf_write_o[%0d].idx", i), 32'(rf_write_o[i].idx),
                  32'(wb[i].rf.idx));
            check($sformatf("rf_write_o[%0d].data", i), rf_write_o[i].data, wb[i].rf.data);
        end
        // Older excepting slot is the one that traps
        tpc  = wb[0].excp ? wb[0].pc : wb[1].pc;
        tmem = wb[0].excp ? wb[0].mem_addr : wb[1].mem_addr;
        if (wb[0].excp || wb[1].excp) begin
            exp_era   = exp_idle ? tpc + 32'd4 : tpc;
            exp_ecode = rw.ecode;
            exp_esub  = rw.esub;
            if (rw.va == VA_PC) begin
                exp_badv = tpc;
            end else if (rw.va == VA_MEM) begin
                exp_badv = tmem;
            end
            exp_idle = 1'b0;
        end else if (rw.op0 == commit_pkg::OP_IDLE) begin
            exp_idle = 1'b1;
        end
        // Registered state one edge later
        @(negedge clk);
        check("era_o", era_o, exp_era);
        check("badv_o", badv_o, exp_badv);
        check("estat_ecode_o", 32'(estat_ecode_o), 32'(exp_ecode));
        check("estat_esubcode_o", 32'(estat_esubcode_o), 32'(exp_esub));
        check("in_idle_o", 32'(in_idle_o), 32'(exp_idle));
        wb[0].valid = 1'b0;
        wb[1].valid = 1'b0;
        if (errors == errs_before) begin
            $display("row %0d passed", idx);
        end else begin
            $display("row %0d failed with %0d errors", idx, errors - errs_before);
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        wb         = '0;
        ex_ready   = 2'b11;
        mem1_ready = 2'b11;
        mem2_ready = 2'b11;
        csr_wr     = '0;
        fill_table();
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        // Entry vectors go in through the CSR write port
        eentry_val  = lcg_next() & 32'hffff_ffc0;
        tlbr_val    = lcg_next() & 32'hffff_ffc0;
        csr_wr.we   = 1'b1;
        csr_wr.sel  = commit_pkg::CSR_SEL_EENTRY;
        csr_wr.data = eentry_val;
        @(negedge clk);
        csr_wr.sel  = commit_pkg::CSR_SEL_TLBRENTRY;
        csr_wr.data = tlbr_val;
        @(negedge clk);
        csr_wr = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r], r);
        end
        @(negedge clk);
        $display("rows %0d, checks %0d, errors %0d, assertion failures %0d",
                 NUM_ROWS, checks, errors, dut_i.u_checker.fail_count);
        if (errors == 0 && dut_i.u_checker.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held over five rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* logic/commit_ctrl_top.sv */
`timescale 1ns/100ps

module commit_ctrl_top (
    input  logic                                                clk,
    input  logic                                                rst,
    input  commit_pkg::wb_slot_t  [commit_pkg::COMMIT_WIDTH-1:0] wb_i,
    input  logic                  [1:0]                          ex_ready_i,
    input  logic                  [1:0]                          mem1_ready_i,
    input  logic                  [1:0]                          mem2_ready_i,
    input  commit_pkg::csr_wr_t                                  csr_wr_i,
    output commit_pkg::rf_write_t [commit_pkg::COMMIT_WIDTH-1:0] rf_write_o,
    output logic                  [commit_pkg::COMMIT_WIDTH-1:0] commit_mask_o,
    output logic                                                 redirect_valid_o,
    output commit_pkg::addr_t                                    redirect_pc_o,
    output logic                                                 in_idle_o,
    output commit_pkg::stage_vec_t                               advance_o,
    output commit_pkg::stage_vec_t                               flush_o,
    output commit_pkg::stage_vec_t                               clear_o,
    output commit_pkg::addr_t                                    era_o,
    output commit_pkg::addr_t                                    badv_o,
    output commit_pkg::ecode_t                                   estat_ecode_o,
    output commit_pkg::esubcode_t                                estat_esubcode_o
);

    commit_pkg::trap_info_t trap;
    commit_pkg::addr_t      eentry;
    commit_pkg::addr_t      tlbrentry;
    logic                   flush_all;

    commit_filter u_commit_filter (
        .wb_i          (wb_i),
        .rf_write_o    (rf_write_o),
        .commit_mask_o (commit_mask_o)
    );

    excp_encoder u_excp_encoder (
        .wb_i   (wb_i),
        .trap_o (trap)
    );

    redirect_unit u_redirect_unit (
        .clk              (clk),
        .rst              (rst),
        .wb_i             (wb_i),
        .trap_i           (trap),
        .eentry_i         (eentry),
        .tlbrentry_i      (tlbrentry),
        .era_i            (era_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o),
        .flush_all_o      (flush_all),
        .in_idle_o        (in_idle_o)
    );

    stage_ctrl u_stage_ctrl (
        .ex_ready_i   (ex_ready_i),
        .mem1_ready_i (mem1_ready_i),
        .mem2_ready_i (mem2_ready_i),
        .flush_all_i  (flush_all),
        .advance_o    (advance_o),
        .flush_o      (flush_o),
        .clear_o      (clear_o)
    );

    // in_idle feeds back so ERA skips the IDLE on wake-up
    trap_csr u_trap_csr (
        .clk              (clk),
        .rst              (rst),
        .trap_i           (trap),
        .csr_wr_i         (csr_wr_i),
        .in_idle_i        (in_idle_o),
        .eentry_o         (eentry),
        .tlbrentry_o      (tlbrentry),
        .era_o            (era_o),
        .badv_o           (badv_o),
        .estat_ecode_o    (estat_ecode_o),
        .estat_esubcode_o (estat_esubcode_o)
    );

endmodule

/* logic/commit_filter.sv */
`timescale 1ns/100ps

module commit_filter (
    input  commit_pkg::wb_slot_t  [commit_pkg::COMMIT_WIDTH-1:0] wb_i,
    output commit_pkg::rf_write_t [commit_pkg::COMMIT_WIDTH-1:0] rf_write_o,
    output logic                  [commit_pkg::COMMIT_WIDTH-1:0] commit_mask_o
);

    logic [commit_pkg::COMMIT_WIDTH-1:0] slot_excp;
    logic slot0_serial;
    logic slot0_mispredict;

    always_comb begin
        for (int i = 0; i < commit_pkg::COMMIT_WIDTH; i++) begin
            slot_excp[i] = wb_i[i].valid & wb_i[i].excp;
        end
    end

    // These ops end the commit group, so the younger slot is dropped
    assign slot0_serial = wb_i[0].valid &
                          ((wb_i[0].op == commit_pkg::OP_SYSCALL) |
                           (wb_i[0].op == commit_pkg::OP_BRK) |
                           (wb_i[0].op == commit_pkg::OP_ERTN) |
                           (wb_i[0].op == commit_pkg::OP_IDLE));

    // Taken but predicted not taken, slot 1 came from the wrong path
    assign slot0_mispredict = wb_i[0].valid & (wb_i[0].op == commit_pkg::OP_BRANCH) &
                              wb_i[0].is_taken & ~wb_i[0].predicted_taken;

    assign commit_mask_o[0] = wb_i[0].valid & ~slot_excp[0];
    assign commit_mask_o[1] = wb_i[1].valid & ~slot_excp[0] & ~slot_excp[1] &
                              ~slot0_serial & ~slot0_mispredict;

    // Register writes pass through, enables only for committing slots
    always_comb begin
        for (int i = 0; i < commit_pkg::COMMIT_WIDTH; i++) begin
            rf_write_o[i]    = wb_i[i].rf;
            rf_write_o[i].we = wb_i[i].rf.we & commit_mask_o[i];
        end
    end

endmodule

/* logic/commit_pkg.sv */
package commit_pkg;

    // Two write-back slots, slot 0 always the older one
    localparam int COMMIT_WIDTH = 2;

    // Stage vector order is frontend, decode, dispatch, ex, mem1, mem2, wb
    localparam int NUM_STAGES = 7;
    localparam int STG_EX     = 3;
    localparam int STG_MEM1   = 2;
    localparam int STG_MEM2   = 1;
    localparam int STG_WB     = 0;

    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] word_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [15:0] excp_vec_t;
    typedef logic [NUM_STAGES-1:0] stage_vec_t;

    typedef enum logic [2:0] {
        OP_NORMAL,
        OP_BRANCH,
        OP_SYSCALL,
        OP_BRK,
        OP_ERTN,
        OP_IDLE
    } op_kind_e;

    // Cause request bit positions, bit 0 wins over all others
    typedef enum logic [3:0] {
        EXCP_INT, EXCP_ADEF, EXCP_TLBR_F, EXCP_PIF,
        EXCP_PPI_F, EXCP_SYS, EXCP_BRK, EXCP_INE,
        EXCP_IPE, EXCP_ALE, EXCP_ADEM, EXCP_TLBR_M,
        EXCP_PME, EXCP_PPI_M, EXCP_PIS, EXCP_PIL
    } excp_bit_e;

    // ESTAT cause codes
    localparam ecode_t ECODE_INT  = 6'h00;
    localparam ecode_t ECODE_PIL  = 6'h01;
    localparam ecode_t ECODE_PIS  = 6'h02;
    localparam ecode_t ECODE_PIF  = 6'h03;
    localparam ecode_t ECODE_PME  = 6'h04;
    localparam ecode_t ECODE_PPI  = 6'h07;
    localparam ecode_t ECODE_ADE  = 6'h08;
    localparam ecode_t ECODE_ALE  = 6'h09;
    localparam ecode_t ECODE_SYS  = 6'h0b;
    localparam ecode_t ECODE_BRK  = 6'h0c;
    localparam ecode_t ECODE_INE  = 6'h0d;
    localparam ecode_t ECODE_IPE  = 6'h0e;
    localparam ecode_t ECODE_TLBR = 6'h3f;

    localparam esubcode_t ESUBCODE_ADEF = 9'h000;
    localparam esubcode_t ESUBCODE_ADEM = 9'h001;

    typedef struct packed {
        logic     we;
        reg_idx_t idx;
        word_t    data;
    } rf_write_t;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        op_kind_e  op;
        logic      excp;
        excp_vec_t excp_vec;
        addr_t     mem_addr;
        logic      is_taken;
        logic      predicted_taken;
        logic      need_refetch;
        rf_write_t rf;
    } wb_slot_t;

    typedef struct packed {
        logic      excp;
        ecode_t    ecode;
        esubcode_t esubcode;
        logic      va_valid;
        addr_t     bad_va;
        logic      tlbrefill;
        addr_t     pc;
    } trap_info_t;

    typedef enum logic {
        CSR_SEL_EENTRY,
        CSR_SEL_TLBRENTRY
    } csr_sel_e;

    typedef struct packed {
        logic     we;
        csr_sel_e sel;
        addr_t    data;
    } csr_wr_t;

endpackage

/* logic/excp_encoder.sv */
`timescale 1ns/100ps

module excp_encoder (
    input  commit_pkg::wb_slot_t [commit_pkg::COMMIT_WIDTH-1:0] wb_i,
    output commit_pkg::trap_info_t                              trap_o
);

    logic [commit_pkg::COMMIT_WIDTH-1:0] slot_excp;
    commit_pkg::wb_slot_t  sel_slot;
    commit_pkg::excp_bit_e cause;
    logic va_from_pc;
    logic va_from_mem;

    always_comb begin
        for (int i = 0; i < commit_pkg::COMMIT_WIDTH; i++) begin
            slot_excp[i] = wb_i[i].valid & wb_i[i].excp;
        end
    end

    // Older slot takes precedence
    assign sel_slot = slot_excp[0] ? wb_i[0] : wb_i[1];

    // Scan downwards so the lowest set bit is the one that sticks
    always_comb begin
        cause = commit_pkg::EXCP_PIL;
        for (int i = $bits(commit_pkg::excp_vec_t) - 1; i >= 0; i--) begin
            if (sel_slot.excp_vec[i]) begin
                cause = commit_pkg::excp_bit_e'(i);
            end
        end
    end

    always_comb begin
        trap_o      = '0;
        va_from_pc  = 1'b0;
        va_from_mem = 1'b0;
        trap_o.excp = |slot_excp;
        trap_o.pc   = sel_slot.pc;
        if (trap_o.excp && (|sel_slot.excp_vec)) begin
            case (cause)
                commit_pkg::EXCP_INT:    trap_o.ecode = commit_pkg::ECODE_INT;
                commit_pkg::EXCP_ADEF: begin
                    trap_o.ecode    = commit_pkg::ECODE_ADE;
                    trap_o.esubcode = commit_pkg::ESUBCODE_ADEF;
                    va_from_pc      = 1'b1;
                end
                commit_pkg::EXCP_TLBR_F: begin
                    trap_o.ecode     = commit_pkg::ECODE_TLBR;
                    trap_o.tlbrefill = 1'b1;
                    va_from_pc       = 1'b1;
                end
                commit_pkg::EXCP_PIF: begin
                    trap_o.ecode = commit_pkg::ECODE_PIF;
                    va_from_pc   = 1'b1;
                end
                commit_pkg::EXCP_PPI_F: begin
                    trap_o.ecode = commit_pkg::ECODE_PPI;
                    va_from_pc   = 1'b1;
                end
                commit_pkg::EXCP_SYS:    trap_o.ecode = commit_pkg::ECODE_SYS;
                commit_pkg::EXCP_BRK:    trap_o.ecode = commit_pkg::ECODE_BRK;
                commit_pkg::EXCP_INE:    trap_o.ecode = commit_pkg::ECODE_INE;
                commit_pkg::EXCP_IPE:    trap_o.ecode = commit_pkg::ECODE_IPE;
                commit_pkg::EXCP_ALE: begin
                    trap_o.ecode = commit_pkg::ECODE_ALE;
                    va_from_mem  = 1'b1;
                end
                commit_pkg::EXCP_ADEM: begin
                    trap_o.ecode    = commit_pkg::ECODE_ADE;
                    trap_o.esubcode = commit_pkg::ESUBCODE_ADEM;
                    va_from_mem     = 1'b1;
                end
                commit_pkg::EXCP_TLBR_M: begin
                    trap_o.ecode     = commit_pkg::ECODE_TLBR;
                    trap_o.tlbrefill = 1'b1;
                    va_from_mem      = 1'b1;
                end
                commit_pkg::EXCP_PME: begin
                    trap_o.ecode = commit_pkg::ECODE_PME;
                    va_from_mem  = 1'b1;
                end
                commit_pkg::EXCP_PPI_M: begin
                    trap_o.ecode = commit_pkg::ECODE_PPI;
                    va_from_mem  = 1'b1;
                end
                commit_pkg::EXCP_PIS: begin
                    trap_o.ecode = commit_pkg::ECODE_PIS;
                    va_from_mem  = 1'b1;
                end
                default: begin
                    trap_o.ecode = commit_pkg::ECODE_PIL;
                    va_from_mem  = 1'b1;
                end
            endcase
        end
        // Fetch causes blame the PC, memory causes the data address
        if (va_from_pc) begin
            trap_o.va_valid = 1'b1;
            trap_o.bad_va   = sel_slot.pc;
        end else if (va_from_mem) begin
            trap_o.va_valid = 1'b1;
            trap_o.bad_va   = sel_slot.mem_addr;
        end
    end

endmodule

/* logic/redirect_unit.sv */
`timescale 1ns/100ps

module redirect_unit (
    input  logic                                               clk,
    input  logic                                               rst,
    input  commit_pkg::wb_slot_t [commit_pkg::COMMIT_WIDTH-1:0] wb_i,
    input  commit_pkg::trap_info_t                              trap_i,
    input  commit_pkg::addr_t                                   eentry_i,
    input  commit_pkg::addr_t                                   tlbrentry_i,
    input  commit_pkg::addr_t                                   era_i,
    output logic                                                redirect_valid_o,
    output commit_pkg::addr_t                                   redirect_pc_o,
    output logic                                                flush_all_o,
    output logic                                                in_idle_o
);

    logic excp_flush;
    logic ertn_flush;
    logic idle_flush;
    logic refetch_flush;

    assign excp_flush    = trap_i.excp;
    // ertn may sit in either slot
    assign ertn_flush    = (wb_i[0].valid & (wb_i[0].op == commit_pkg::OP_ERTN)) |
                           (wb_i[1].valid & (wb_i[1].op == commit_pkg::OP_ERTN));
    assign idle_flush    = wb_i[0].valid & (wb_i[0].op == commit_pkg::OP_IDLE);
    assign refetch_flush = wb_i[0].valid & wb_i[0].need_refetch;

    assign flush_all_o      = excp_flush | ertn_flush | idle_flush | refetch_flush;
    assign redirect_valid_o = flush_all_o;

    // Priority order matters here, exception first
    always_comb begin
        if (excp_flush) begin
            redirect_pc_o = trap_i.tlbrefill ? tlbrentry_i : eentry_i;
        end else if (ertn_flush) begin
            redirect_pc_o = era_i;
        end else if (idle_flush) begin
            redirect_pc_o = wb_i[0].pc;
        end else if (refetch_flush) begin
            redirect_pc_o = wb_i[0].pc + 32'd4;
        end else begin
            redirect_pc_o = '0;
        end
    end

    // Core sleeps after IDLE until something traps
    always_ff @(posedge clk) begin
        if (rst) begin
            in_idle_o <= 1'b0;
        end else if (excp_flush) begin
            in_idle_o <= 1'b0;
        end else if (idle_flush) begin
            in_idle_o <= 1'b1;
        end
    end

endmodule

/* logic/stage_ctrl.sv */
`timescale 1ns/100ps

module stage_ctrl (
    input  logic [1:0]             ex_ready_i,
    input  logic [1:0]             mem1_ready_i,
    input  logic [1:0]             mem2_ready_i,
    input  logic                   flush_all_i,
    output commit_pkg::stage_vec_t advance_o,
    output commit_pkg::stage_vec_t flush_o,
    output commit_pkg::stage_vec_t clear_o
);

    logic mem2_go;
    logic mem1_go;
    logic upper_go;

    // A stage moves only when everything downstream can take its data
    assign mem2_go  = &mem2_ready_i;
    assign mem1_go  = mem2_go & (&mem1_ready_i);
    assign upper_go = mem1_go & (&ex_ready_i);

    always_comb begin
        advance_o = {commit_pkg::NUM_STAGES{upper_go}};
        advance_o[commit_pkg::STG_MEM1] = mem1_go;
        advance_o[commit_pkg::STG_MEM2] = mem2_go;
        advance_o[commit_pkg::STG_WB]   = 1'b1;
    end

    // Bubble goes into the gap between a stalled stage and a moving one
    always_comb begin
        clear_o = '0;
        for (int i = commit_pkg::STG_WB + 1; i < commit_pkg::NUM_STAGES; i++) begin
            clear_o[i] = advance_o[i-1] & ~advance_o[i];
        end
    end

    assign flush_o = {commit_pkg::NUM_STAGES{flush_all_i}};

endmodule

/* logic/trap_csr.sv */
`timescale 1ns/100ps

module trap_csr (
    input  logic                   clk,
    input  logic                   rst,
    input  commit_pkg::trap_info_t trap_i,
    input  commit_pkg::csr_wr_t    csr_wr_i,
    input  logic                   in_idle_i,
    output commit_pkg::addr_t      eentry_o,
    output commit_pkg::addr_t      tlbrentry_o,
    output commit_pkg::addr_t      era_o,
    output commit_pkg::addr_t      badv_o,
    output commit_pkg::ecode_t     estat_ecode_o,
    output commit_pkg::esubcode_t  estat_esubcode_o
);

    // Trap recording
    always_ff @(posedge clk) begin
        if (rst) begin
            era_o            <= '0;
            badv_o           <= '0;
            estat_ecode_o    <= '0;
            estat_esubcode_o <= '0;
        end else if (trap_i.excp) begin
            // Waking from idle returns past the IDLE instruction
            era_o            <= in_idle_i ? trap_i.pc + 32'd4 : trap_i.pc;
            estat_ecode_o    <= trap_i.ecode;
            estat_esubcode_o <= trap_i.esubcode;
            if (trap_i.va_valid) begin
                badv_o <= trap_i.bad_va;
            end
        end
    end

    // Entry vectors, software writes only
    always_ff @(posedge clk) begin
        if (rst) begin
            eentry_o    <= '0;
            tlbrentry_o <= '0;
        end else if (csr_wr_i.we) begin
            if (csr_wr_i.sel == commit_pkg::CSR_SEL_EENTRY) begin
                eentry_o <= csr_wr_i.data;
            end else begin
                tlbrentry_o <= csr_wr_i.data;
            end
        end
    end

endmodule

/* tb.f */
logic/commit_pkg.sv
logic/commit_filter.sv
logic/excp_encoder.sv
logic/redirect_unit.sv
logic/stage_ctrl.sv
logic/trap_csr.sv
logic/commit_ctrl_top.sv
bench/tb_clock.sv
bench/commit_checker.sv
bench/commit_tb.sv
